/* Makefile */
# Verilator flow for the stack and accumulator core
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* alu.sv */
/*
 * Integer ALU with the accumulator register.
 * Picks the operand, computes the next value and registers it.
 */
`timescale 1ns/1ps

module alu (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::alu_sel_e alu_sel,
	input  cpu_pkg::data_t    mem_data_rd,
	input  cpu_pkg::data_t    stack_top,
	input  cpu_pkg::data_t    io_in,
	output cpu_pkg::data_t    acc,
	output logic              acc_zero
);
	import cpu_pkg::*;

	data_t acc_next;

	// ------------------------------------------------------------------
	// Next accumulator value
	// ------------------------------------------------------------------
	always_comb begin
		case (alu_sel)
			KEEP:      acc_next = acc;
			MEM:       acc_next = mem_data_rd;
			STACK:     acc_next = stack_top;
			IO:        acc_next = io_in;
			// Sums wrap at the data width
			ADD_MEM:   acc_next = acc + mem_data_rd;
			AND_MEM:   acc_next = acc & mem_data_rd;
			XOR_MEM:   acc_next = acc ^ mem_data_rd;
			ADD_STACK: acc_next = acc + stack_top;
			default:   acc_next = acc;
		endcase
	end

	// ------------------------------------------------------------------
	// Accumulator
	// ------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			acc <= '0;
		end else begin
			acc <= acc_next;
		end
	end

	// JIZ looks at the registered value
	assign acc_zero = (acc == '0);

endmodule

/* compile.f */
cpu_pkg.sv
lifo.sv
instr_fetch.sv
instr_dec.sv
alu.sv
io_ctrl.sv
core.sv
tb_core.sv

/* core.sv */
/*
 * Stack and accumulator processor core, one instruction per cycle.
 * Instruction and data memories sit outside and are read combinationally.
 */
`timescale 1ns/1ps

module core (
	input  logic              clk,
	input  logic              rst,
	input  cpu_pkg::instr_t   instr,
	output cpu_pkg::iaddr_t   instr_addr,
	output cpu_pkg::daddr_t   mem_addr,
	output logic              mem_wr,
	input  cpu_pkg::data_t    mem_data_rd,
	output cpu_pkg::data_t    mem_data_wr,
	input  cpu_pkg::data_t    io_in,
	output logic              req_in,
	output cpu_pkg::io_addr_t addr_in,
	output logic              out_en,
	output cpu_pkg::io_addr_t addr_out,
	output cpu_pkg::data_t    out_data,
	output logic              halted
);
	import cpu_pkg::*;

	opcode_e                opcode;
	logic [OPERAND_W-1:0]   operand;
	alu_sel_e               alu_sel;
	logic                   push;
	logic                   pop;
	logic                   io_rd;
	logic                   io_wr;
	logic                   jump;
	logic                   jump_if_zero;
	logic                   call;
	logic                   ret;
	logic                   acc_zero;
	data_t                  acc;
	data_t                  stack_top;

	// ------------------------------------------------------------------
	// Fetch and decode
	// ------------------------------------------------------------------
	instr_fetch u_fetch (
		.clk          (clk),
		.rst          (rst),
		.instr        (instr),
		.jump         (jump),
		.jump_if_zero (jump_if_zero),
		.call         (call),
		.ret          (ret),
		.acc_zero     (acc_zero),
		.instr_addr   (instr_addr),
		.opcode       (opcode),
		.operand      (operand),
		.halted       (halted)
	);

	instr_dec u_dec (
		.rst          (rst),
		.halted       (halted),
		.opcode       (opcode),
		.alu_sel      (alu_sel),
		.mem_wr       (mem_wr),
		.push         (push),
		.pop          (pop),
		.io_rd        (io_rd),
		.io_wr        (io_wr),
		.jump         (jump),
		.jump_if_zero (jump_if_zero),
		.call         (call),
		.ret          (ret)
	);

	// ------------------------------------------------------------------
	// Datapath
	// ------------------------------------------------------------------
	lifo #(
		.WIDTH (DATA_W),
		.DEPTH (DATA_DEPTH)
	) data_stack (
		.clk  (clk),
		.rst  (rst),
		.push (push),
		.pop  (pop),
		.din  (acc),
		.top  (stack_top)
	);

	alu u_alu (
		.clk         (clk),
		.rst         (rst),
		.alu_sel     (alu_sel),
		.mem_data_rd (mem_data_rd),
		.stack_top   (stack_top),
		.io_in       (io_in),
		.acc         (acc),
		.acc_zero    (acc_zero)
	);

	// Direct addressing only
	assign mem_addr    = operand[DADDR_W-1:0];
	assign mem_data_wr = acc;

	io_ctrl u_io (
		.clk      (clk),
		.rst      (rst),
		.io_rd    (io_rd),
		.io_wr    (io_wr),
		.operand  (operand),
		.acc      (acc),
		.req_in   (req_in),
		.addr_in  (addr_in),
		.out_en   (out_en),
		.addr_out (addr_out),
		.out_data (out_data)
	);

endmodule

/* cpu_pkg.sv */
/*
 * Shared definitions of the stack and accumulator core.
 * Widths, vector types, opcodes and the accumulator source select.
 */
package cpu_pkg;

	// ------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------
	localparam int OPCODE_W  = 7;
	localparam int OPERAND_W = 9;
	localparam int INSTR_W   = OPCODE_W + OPERAND_W;
	localparam int DATA_W    = 16;
	localparam int IADDR_W   = 9;
	localparam int DADDR_W   = 9;
	localparam int IO_ADDR_W = 2;

	// Stack depths in entries
	localparam int CALL_DEPTH = 8;
	localparam int DATA_DEPTH = 8;

	typedef logic [INSTR_W-1:0]   instr_t;
	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [IADDR_W-1:0]   iaddr_t;
	typedef logic [DADDR_W-1:0]   daddr_t;
	typedef logic [IO_ADDR_W-1:0] io_addr_t;

	// ------------------------------------------------------------------
	// Opcodes
	// ------------------------------------------------------------------
	// Codes not listed here execute as NOP
	typedef enum logic [OPCODE_W-1:0] {
		NOP   = 7'd0,
		LOD   = 7'd1,
		SET   = 7'd2,
		PSH   = 7'd3,
		POP   = 7'd4,
		ADD   = 7'd5,
		AND   = 7'd6,
		XOR   = 7'd7,
		S_ADD = 7'd8,
		INN   = 7'd9,
		OUT   = 7'd10,
		JMP   = 7'd13,
		JIZ   = 7'd14,
		CAL   = 7'd15,
		RET   = 7'd16,
		HLT   = 7'd31
	} opcode_e;

	// Source of the next accumulator value
	typedef enum logic [2:0] {
		KEEP,
		MEM,
		STACK,
		IO,
		ADD_MEM,
		AND_MEM,
		XOR_MEM,
		ADD_STACK
	} alu_sel_e;

endpackage

/* instr_dec.sv */
/*
 * Combinational instruction decoder.
 * Turns the opcode into ALU, memory, stack, I/O and branch controls.
 */
`timescale 1ns/1ps

module instr_dec (
	input  logic              rst,
	input  logic              halted,
	input  cpu_pkg::opcode_e  opcode,
	output cpu_pkg::alu_sel_e alu_sel,
	output logic              mem_wr,
	output logic              push,
	output logic              pop,
	output logic              io_rd,
	output logic              io_wr,
	output logic              jump,
	output logic              jump_if_zero,
	output logic              call,
	output logic              ret
);
	import cpu_pkg::*;

	always_comb begin
		alu_sel      = KEEP;
		mem_wr       = 1'b0;
		push         = 1'b0;
		pop          = 1'b0;
		io_rd        = 1'b0;
		io_wr        = 1'b0;
		jump         = 1'b0;
		jump_if_zero = 1'b0;
		call         = 1'b0;
		ret          = 1'b0;

		// Nothing leaves the decoder in reset or after HLT
		if (!rst && !halted) begin
			case (opcode)
				LOD:     alu_sel = MEM;
				SET:     mem_wr  = 1'b1;
				PSH:     push    = 1'b1;
				POP: begin
					pop     = 1'b1;
					alu_sel = STACK;
				end
				ADD:     alu_sel = ADD_MEM;
				AND:     alu_sel = AND_MEM;
				XOR:     alu_sel = XOR_MEM;
				// Operand is the stack top, removed in the same cycle
				S_ADD: begin
					pop     = 1'b1;
					alu_sel = ADD_STACK;
				end
				INN: begin
					io_rd   = 1'b1;
					alu_sel = IO;
				end
				OUT:     io_wr        = 1'b1;
				JMP:     jump         = 1'b1;
				JIZ:     jump_if_zero = 1'b1;
				CAL:     call         = 1'b1;
				RET:     ret          = 1'b1;
				default: alu_sel      = KEEP;
			endcase
		end
	end

endmodule

/* instr_fetch.sv */
/*
 * Instruction fetch: program counter, next address selection,
 * call stack and the sticky halt state.
 */
`timescale 1ns/1ps

module instr_fetch (
	input  logic                          clk,
	input  logic                          rst,
	input  cpu_pkg::instr_t               instr,
	input  logic                          jump,
	input  logic                          jump_if_zero,
	input  logic                          call,
	input  logic                          ret,
	input  logic                          acc_zero,
	output cpu_pkg::iaddr_t               instr_addr,
	output cpu_pkg::opcode_e              opcode,
	output logic [cpu_pkg::OPERAND_W-1:0] operand,
	output logic                          halted
);
	import cpu_pkg::*;

	iaddr_t pc;
	iaddr_t pc_inc;
	iaddr_t pc_next;
	iaddr_t ret_addr;
	logic   take_target;

	// Opcode in the upper bits, operand in the lower bits
	assign opcode  = opcode_e'(instr[INSTR_W-1 -: OPCODE_W]);
	assign operand = instr[OPERAND_W-1:0];

	assign instr_addr  = pc;
	assign pc_inc      = pc + IADDR_W'(1);
	assign take_target = jump | call | (jump_if_zero & acc_zero);

	// ------------------------------------------------------------------
	// Next address
	// ------------------------------------------------------------------
	// HLT parks the PC on itself, so the address stays on the HLT word
	always_comb begin
		if (halted || opcode == HLT) begin
			pc_next = pc;
		end else if (ret) begin
			pc_next = ret_addr;
		end else if (take_target) begin
			pc_next = operand[IADDR_W-1:0];
		end else begin
			pc_next = pc_inc;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc     <= '0;
			halted <= 1'b0;
		end else begin
			pc <= pc_next;
			if (opcode == HLT) begin
				halted <= 1'b1;
			end
		end
	end

	// CAL saves the address after the call on this stack
	lifo #(
		.WIDTH (IADDR_W),
		.DEPTH (CALL_DEPTH)
	) call_stack (
		.clk  (clk),
		.rst  (rst),
		.push (call),
		.pop  (ret),
		.din  (pc_inc),
		.top  (ret_addr)
	);

	a_halt_freezes_pc : assert property (@(posedge clk) disable iff (rst)
		halted |=> $stable(pc));

endmodule

/* io_ctrl.sv */
/*
 * I/O port control: input request during the INN cycle and a
 * registered output strobe with port address and data after OUT.
 */
`timescale 1ns/1ps

module io_ctrl (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          io_rd,
	input  logic                          io_wr,
	input  logic [cpu_pkg::OPERAND_W-1:0] operand,
	input  cpu_pkg::data_t                acc,
	output logic                          req_in,
	output cpu_pkg::io_addr_t             addr_in,
	output logic                          out_en,
	output cpu_pkg::io_addr_t             addr_out,
	output cpu_pkg::data_t                out_data
);
	import cpu_pkg::*;

	// Input side is combinational, sampled by the ALU in the same cycle
	assign req_in  = io_rd;
	assign addr_in = operand[IO_ADDR_W-1:0];

	// Strobe lasts one cycle per OUT
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_en <= 1'b0;
		end else begin
			out_en <= io_wr;
		end
	end

	always_ff @(posedge clk) begin
		if (io_wr) begin
			addr_out <= operand[IO_ADDR_W-1:0];
			out_data <= acc;
		end
	end

endmodule

/* lifo.sv */
/*
 * Last-in-first-out stack with a combinational top.
 * Used both as the call stack and as the data stack.
 */
`timescale 1ns/1ps

module lifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 8
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             push,
	input  logic             pop,
	input  logic [WIDTH-1:0] din,
	output logic [WIDTH-1:0] top
);
	localparam int IDX_W = $clog2(DEPTH);
	// One extra bit so a full stack can be told from an empty one
	localparam int PTR_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] ptr;
	logic [PTR_W-1:0] ptr_dec;

	assign ptr_dec = ptr - PTR_W'(1);

	// Pointer always marks the next free slot
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + PTR_W'(1);
		end else if (pop) begin
			ptr <= ptr_dec;
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr[IDX_W-1:0]] <= din;
		end
	end

	assign top = mem[ptr_dec[IDX_W-1:0]];

	a_no_overflow : assert property (@(posedge clk) disable iff (rst)
		push |-> ptr != PTR_W'(DEPTH));
	a_no_underflow : assert property (@(posedge clk) disable iff (rst)
		pop |-> ptr != '0);
	a_no_push_pop : assert property (@(posedge clk) disable iff (rst)
		!(push && pop));

endmodule

/* tb_core.sv */
/*
 * Testbench of the stack and accumulator core.
 * Models the program ROM, data RAM and input ports, and checks memory
 * writes, control flow, I/O strobes and halt with concurrent assertions.
 */
`timescale 1ns/1ps

module tb_core;
	import cpu_pkg::*;

	localparam int        PROG_LEN    = 43;
	localparam int        CYCLE_LIMIT = 4 * PROG_LEN + 50;
	localparam logic [3:0] N_WRITES   = 4'd8;
	localparam daddr_t    POISON_ADDR = 9'd30;
	localparam io_addr_t  INN_PORT    = 2'd2;
	localparam io_addr_t  OUT_PORT    = 2'd3;
	localparam iaddr_t    HLT_ADDR    = 9'd33;
	// Addresses that only a wrong branch decision can reach
	localparam iaddr_t    SKIP_0      = 9'd21;
	localparam iaddr_t    SKIP_1      = 9'd22;
	localparam iaddr_t    SKIP_2      = 9'd26;

	logic     clk;
	logic     rst;
	instr_t   instr;
	iaddr_t   instr_addr;
	daddr_t   mem_addr;
	logic     mem_wr;
	data_t    mem_data_rd;
	data_t    mem_data_wr;
	data_t    io_in;
	logic     req_in;
	io_addr_t addr_in;
	logic     out_en;
	io_addr_t addr_out;
	data_t    out_data;
	logic     halted;

	instr_t     rom [512];
	data_t      ram [512];
	data_t      io_src [4];
	daddr_t     exp_addr [8];
	data_t      exp_val [8];
	data_t      out_expect;
	logic [3:0] wr_idx = 4'd0;
	int         cycles = 0;
	int         seed;
	opcode_e    exec_op;
	logic       out_exec;
	logic       inn_exec;
	logic       hlt_exec;

	core UUT (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_addr  (instr_addr),
		.mem_addr    (mem_addr),
		.mem_wr      (mem_wr),
		.mem_data_rd (mem_data_rd),
		.mem_data_wr (mem_data_wr),
		.io_in       (io_in),
		.req_in      (req_in),
		.addr_in     (addr_in),
		.out_en      (out_en),
		.addr_out    (addr_out),
		.out_data    (out_data),
		.halted      (halted)
	);

	// ------------------------------------------------------------------
	// Memory and port models
	// ------------------------------------------------------------------
	assign instr       = rom[instr_addr];
	assign mem_data_rd = ram[mem_addr];
	assign io_in       = io_src[addr_in];

	// Instruction in its executing cycle
	assign exec_op  = opcode_e'(instr[INSTR_W-1 -: OPCODE_W]);
	assign out_exec = !rst && !halted && exec_op == OUT;
	assign inn_exec = !rst && !halted && exec_op == INN;
	assign hlt_exec = !rst && !halted && exec_op == HLT;

	always @(posedge clk) begin
		if (mem_wr) begin
			ram[mem_addr] <= mem_data_wr;
			wr_idx        <= wr_idx + 4'd1;
		end
	end

	task automatic stop_on_failure(input string line);
		$display("%s", line);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic value_error(input string what);
		stop_on_failure($sformatf("Error at %0t ns: %s", $time, what));
	endtask

	task automatic put_instr(input int addr, input opcode_e op, input int arg);
		rom[iaddr_t'(addr)] = {op, OPERAND_W'(arg)};
	endtask

	task automatic expect_write(input int idx, input int addr, input data_t value);
		exp_addr[3'(idx)] = daddr_t'(addr);
		exp_val[3'(idx)]  = value;
	endtask

	// ------------------------------------------------------------------
	// Clock, program and run control
	// ------------------------------------------------------------------
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		rst  = 1'b1;
		seed = 78189;
		// Stray fetches land on HLT words
		for (int i = 0; i < 512; i++) begin
			put_instr(i, HLT, i);
			ram[iaddr_t'(i)] = data_t'($random(seed));
		end
		for (int p = 0; p < 4; p++) begin
			io_src[2'(p)] = data_t'($random(seed));
		end
		// Word 5 must be nonzero for the fall-through JIZ
		ram[9'd5][0] = 1'b1;

		put_instr(0, LOD, 0);
		put_instr(1, ADD, 1);
		put_instr(2, SET, 16);
		put_instr(3, LOD, 0);
		put_instr(4, AND, 1);
		put_instr(5, SET, 17);
		put_instr(6, LOD, 0);
		put_instr(7, XOR, 1);
		put_instr(8, SET, 18);
		// Stack order x, y then z + y and x back
		put_instr(9, LOD, 2);
		put_instr(10, PSH, 0);
		put_instr(11, LOD, 3);
		put_instr(12, PSH, 0);
		put_instr(13, LOD, 4);
		put_instr(14, S_ADD, 0);
		put_instr(15, SET, 19);
		put_instr(16, POP, 0);
		put_instr(17, SET, 20);
		// a ^ a clears the accumulator
		put_instr(18, LOD, 0);
		put_instr(19, XOR, 0);
		put_instr(20, JIZ, 23);
		put_instr(21, SET, 30);
		put_instr(22, SET, 30);
		put_instr(23, LOD, 5);
		put_instr(24, JIZ, 21);
		put_instr(25, JMP, 27);
		put_instr(26, SET, 30);
		put_instr(27, CAL, 40);
		put_instr(28, LOD, 7);
		put_instr(29, SET, 22);
		put_instr(30, INN, INN_PORT);
		put_instr(31, SET, 23);
		put_instr(32, OUT, OUT_PORT);
		put_instr(33, HLT, 0);
		// Subroutine
		put_instr(40, LOD, 6);
		put_instr(41, SET, 21);
		put_instr(42, RET, 0);

		expect_write(0, 16, ram[9'd0] + ram[9'd1]);
		expect_write(1, 17, ram[9'd0] & ram[9'd1]);
		expect_write(2, 18, ram[9'd0] ^ ram[9'd1]);
		expect_write(3, 19, ram[9'd4] + ram[9'd3]);
		expect_write(4, 20, ram[9'd2]);
		expect_write(5, 21, ram[9'd6]);
		expect_write(6, 22, ram[9'd7]);
		expect_write(7, 23, io_src[INN_PORT]);
		out_expect = io_src[INN_PORT];

		repeat (5) @(posedge clk);
		rst <= 1'b0;
		while (!(halted && wr_idx == N_WRITES)) begin
			@(posedge clk);
		end
		// A few cycles of the halted state
		repeat (4) @(posedge clk);
		$display("All checks passed");
		$finish;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			stop_on_failure($sformatf("Timeout: program did not halt within %0d cycles", cycles));
		end
	end

	// ------------------------------------------------------------------
	// Assertions
	// ------------------------------------------------------------------
	a_reset : assert property (@(posedge clk) (rst || $past(rst)) |->
		(!mem_wr && !req_in && !out_en && instr_addr == '0))
		else value_error("core active during or right after reset");

	a_write_order : assert property (@(posedge clk) disable iff (rst)
		mem_wr |-> (wr_idx < N_WRITES && mem_addr == exp_addr[wr_idx[2:0]]))
		else value_error("write to an unexpected address");
	a_write_value : assert property (@(posedge clk) disable iff (rst)
		mem_wr |-> mem_data_wr == exp_val[wr_idx[2:0]])
		else value_error("written value differs from the expected result");
	a_no_poison : assert property (@(posedge clk) disable iff (rst)
		mem_wr |-> mem_addr != POISON_ADDR)
		else value_error("skipped instruction wrote the poison address");

	a_branch : assert property (@(posedge clk) disable iff (rst)
		instr_addr != SKIP_0 && instr_addr != SKIP_1 && instr_addr != SKIP_2)
		else value_error("fetch from an address a branch should skip");

	a_inn : assert property (@(posedge clk) disable iff (rst)
		req_in == inn_exec && (inn_exec -> addr_in == INN_PORT))
		else value_error("input request or port address wrong");
	a_out : assert property (@(posedge clk) disable iff (rst)
		out_exec |=> (out_en && addr_out == OUT_PORT && out_data == out_expect))
		else value_error("output strobe, port or data wrong after OUT");
	a_out_single : assert property (@(posedge clk) disable iff (rst)
		!out_exec |=> !out_en)
		else value_error("output strobe without a preceding OUT");

	a_halt_rise : assert property (@(posedge clk) disable iff (rst)
		hlt_exec |=> halted)
		else value_error("halted did not rise after HLT");
	a_halt_addr : assert property (@(posedge clk) disable iff (rst)
		halted |-> (instr_addr == HLT_ADDR ##1 $stable(instr_addr)))
		else value_error("instruction address moved while halted");

endmodule
